// File: axis_cfg.svh
/*
 * Build-time configuration of the stream merger.
 * The data width must stay at 8 because the frame header is one byte.
 * The port count must lie between 2 and 4 so that a port number fits in 2 bits.
 * Each port FIFO holds 2**AXIS_FIFO_ADDR_WIDTH entries plus one output register.
 */
`ifndef AXIS_CFG_SVH
`define AXIS_CFG_SVH

// ********************************************************************
// stream geometry
// ********************************************************************

`define AXIS_DATA_WIDTH 8 // one byte per beat, header included.

`define AXIS_FIFO_ADDR_WIDTH 4 // log2 of the memory depth of each port FIFO.

`define AXIS_NUM_PORTS 3 // number of merged input streams.

`endif

// File: stream_pkg.sv
/*
 * Layout of one output byte of the merged stream.
 * The first beat of every frame is a header and all later beats are payload.
 * The header width is tied to AXIS_DATA_WIDTH, so the data width must be 8.
 */
`include "axis_cfg.svh"

package stream_pkg;

    localparam int SEQ_W = 6; // per-port frame sequence number, wraps after 64 frames.
    localparam int SRC_W = `AXIS_DATA_WIDTH - SEQ_W; // source port number field.

    // header beat, the source port sits in the top bits.
    typedef struct packed {
        logic [SRC_W-1:0] src; // port the frame came in on.
        logic [SEQ_W-1:0] seq; // count of earlier frames from that port.
    } frame_hdr_t;

    // one output byte, read as a header or as plain payload.
    typedef union packed {
        frame_hdr_t                  hdr; // first beat of a frame.
        logic [`AXIS_DATA_WIDTH-1:0] raw; // any other beat.
    } out_word_u;

endpackage

// File: arb_pkg.sv
/*
 * Types shared by the arbiter, the tagging mux and the top level.
 * A port number is 2 bits wide, so at most 4 input ports are supported.
 */
package arb_pkg;

    typedef logic [1:0] port_idx_t; // input port number.

    // arbiter state.
    typedef enum logic {
        ARB_IDLE, // no grant, searching for a requesting port.
        ARB_BUSY  // grant held until the granted frame ends.
    } arb_state_t;

    // tagging mux state.
    typedef enum logic {
        MUX_HDR, // next output beat is the header.
        MUX_PAY  // next output beat comes from the granted FIFO.
    } mux_state_t;

endpackage

// File: axis_fifo.sv
/*
 * Stream FIFO with a registered output stage.
 * A beat written on one edge shows on the output no earlier than the next edge.
 * Capacity is 2**ADDR_WIDTH memory entries plus the output register.
 * tlast and tuser are stored next to the data and come out unchanged.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module axis_fifo #(
    parameter int ADDR_WIDTH = `AXIS_FIFO_ADDR_WIDTH,
    parameter int DATA_WIDTH = `AXIS_DATA_WIDTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] in_tdata,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    output logic [DATA_WIDTH-1:0] out_tdata,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,
    output logic                  out_tuser
);

    localparam int WORD_W = DATA_WIDTH + 2; // data plus tlast and tuser.

    logic [ADDR_WIDTH:0] wr_ptr; // one extra bit tells full from empty.
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [WORD_W-1:0]   mem [2**ADDR_WIDTH];
    logic [WORD_W-1:0]   out_word; // output register contents.
    logic                out_valid; // output register holds a beat.
    logic                full;
    logic                empty;
    logic                write;
    logic                read;

    // ********************************************************************
    // status and handshake
    // ********************************************************************

    // same low bits but a different wrap bit means the writer is one lap ahead.
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);
    assign empty = (wr_ptr == rd_ptr); // identical pointers mean nothing stored.

    assign write = in_tvalid && !full; // accept whenever there is room.
    assign read  = (out_tready || !out_valid) && !empty; // refill when drained or empty.

    assign in_tready  = !full; // high after reset since the memory starts empty.
    assign out_tvalid = out_valid;
    assign {out_tlast, out_tuser, out_tdata} = out_word;

    // ********************************************************************
    // storage
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= {in_tlast, in_tuser, in_tdata}; // pack sideband on top.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr + 1'b1; // wraps naturally through the extra bit.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (read) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // output register, held while the consumer stalls.
    always_ff @(posedge clk) begin
        if (read) begin
            out_word <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (out_tready || !out_valid) begin
            out_valid <= !empty; // valid follows whether a refill took place.
        end
    end

endmodule

// File: axis_frame_arb.sv
/*
 * Round-robin frame arbiter.
 * A grant is registered one edge after a request is seen while idle.
 * The grant is held until frame_done, then the next search starts one port
 * past the last winner. A request that drops before it is granted loses its turn.
 * NUM_PORTS must lie between 2 and 4.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module axis_frame_arb #(
    parameter int NUM_PORTS = `AXIS_NUM_PORTS
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_PORTS-1:0] request,
    input  logic                 frame_done,
    output arb_pkg::port_idx_t   grant,
    output logic                 grant_valid
);

    import arb_pkg::*;

    arb_state_t state;
    port_idx_t  next_port; // winner of the current search.
    logic       found; // at least one port is requesting.

    // ********************************************************************
    // round-robin search
    // ********************************************************************

    // grant keeps the last winner while idle, so the scan starts just after it.
    always_comb begin
        found     = 1'b0;
        next_port = grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            if (!found && request[(int'(grant) + i) % NUM_PORTS]) begin
                found     = 1'b1; // first hit in rotated order wins.
                next_port = port_idx_t'((int'(grant) + i) % NUM_PORTS);
            end
        end
    end

    // ********************************************************************
    // grant state
    // ********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= port_idx_t'(NUM_PORTS - 1); // makes the first scan begin at port 0.
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant <= next_port; // lock onto the winner for one frame.
                        state <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (frame_done) begin
                        state <= ARB_IDLE; // the next grant can follow one edge later.
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    assign grant_valid = (state == ARB_BUSY); // low after reset and between frames.

endmodule

// File: axis_tag_mux.sv
/*
 * Output multiplexer that tags every frame with a one-byte header.
 * The header carries the source port and a 6-bit per-port frame count.
 * Only the granted FIFO sees tready, and only during payload beats.
 * frame_done is combinational and marks the edge on which the last beat is taken.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module axis_tag_mux #(
    parameter int NUM_PORTS = `AXIS_NUM_PORTS
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  arb_pkg::port_idx_t                     grant,
    input  logic                                   grant_valid,
    input  logic [NUM_PORTS*`AXIS_DATA_WIDTH-1:0]  fifo_tdata,
    input  logic [NUM_PORTS-1:0]                   fifo_tvalid,
    output logic [NUM_PORTS-1:0]                   fifo_tready,
    input  logic [NUM_PORTS-1:0]                   fifo_tlast,
    input  logic [NUM_PORTS-1:0]                   fifo_tuser,
    output logic [`AXIS_DATA_WIDTH-1:0]            out_tdata,
    output logic                                   out_tvalid,
    input  logic                                   out_tready,
    output logic                                   out_tlast,
    output logic                                   out_tuser,
    output logic                                   frame_done
);

    import arb_pkg::*;
    import stream_pkg::*;

    localparam int DW = `AXIS_DATA_WIDTH;

    mux_state_t       state;
    logic [SEQ_W-1:0] seq_cnt [NUM_PORTS]; // frames already sent per port.
    out_word_u        word; // byte presented on the output.
    logic             in_pay; // current beat is payload.
    logic             accept; // output beat transfers this edge.

    // ********************************************************************
    // output beat
    // ********************************************************************

    assign in_pay     = (state == MUX_PAY);
    assign out_tvalid = grant_valid && fifo_tvalid[grant]; // header waits for frame data too.
    assign accept     = out_tvalid && out_tready;
    assign out_tlast  = in_pay && fifo_tlast[grant]; // header beats never end a frame.
    assign out_tuser  = in_pay && fifo_tuser[grant];
    assign frame_done = accept && in_pay && fifo_tlast[grant];

    // payload by default, overlaid with the header fields on the first beat.
    always_comb begin
        word.raw = fifo_tdata[grant*DW +: DW];
        if (!in_pay) begin
            word.hdr = '{src: grant, seq: seq_cnt[grant]};
        end
    end

    assign out_tdata = word.raw;

    // only the granted FIFO is drained, and never while the header is out.
    always_comb begin
        fifo_tready = '0;
        if (grant_valid && in_pay) begin
            fifo_tready[grant] = out_tready;
        end
    end

    // ********************************************************************
    // frame sequencing
    // ********************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MUX_HDR;
            for (int p = 0; p < NUM_PORTS; p++) begin
                seq_cnt[p] <= '0;
            end
        end else if (accept) begin
            if (!in_pay) begin
                state <= MUX_PAY; // header taken, stream the frame body next.
            end else if (frame_done) begin
                state          <= MUX_HDR; // next grant starts with a fresh header.
                seq_cnt[grant] <= seq_cnt[grant] + 1'b1; // wraps after 64 frames.
            end
        end
    end

endmodule

// File: axis_merge_top.sv
/*
 * Merger of NUM_PORTS byte streams onto one tagged output stream.
 * Input fields are flat vectors with one slice per port, port 0 at the bottom.
 * Frames are never interleaved at the output. Each one is preceded by its header.
 * Latency depends on arbitration and output stalls.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module axis_merge_top #(
    parameter int NUM_PORTS = `AXIS_NUM_PORTS
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [NUM_PORTS*`AXIS_DATA_WIDTH-1:0] in_tdata,
    input  logic [NUM_PORTS-1:0]                  in_tvalid,
    output logic [NUM_PORTS-1:0]                  in_tready,
    input  logic [NUM_PORTS-1:0]                  in_tlast,
    input  logic [NUM_PORTS-1:0]                  in_tuser,
    output logic [`AXIS_DATA_WIDTH-1:0]           out_tdata,
    output logic                                  out_tvalid,
    input  logic                                  out_tready,
    output logic                                  out_tlast,
    output logic                                  out_tuser
);

    import arb_pkg::*;

    localparam int DW = `AXIS_DATA_WIDTH;

    logic [NUM_PORTS*DW-1:0] fifo_tdata; // FIFO outputs, one slice per port.
    logic [NUM_PORTS-1:0]    fifo_tvalid; // also the arbiter request lines.
    logic [NUM_PORTS-1:0]    fifo_tready;
    logic [NUM_PORTS-1:0]    fifo_tlast;
    logic [NUM_PORTS-1:0]    fifo_tuser;
    port_idx_t               grant;
    logic                    grant_valid;
    logic                    frame_done;

    // ********************************************************************
    // per-port buffering
    // ********************************************************************

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        axis_fifo #(
            .ADDR_WIDTH (`AXIS_FIFO_ADDR_WIDTH),
            .DATA_WIDTH (DW)
        ) u_fifo (
            .clk        (clk),
            .rst        (rst),
            .in_tdata   (in_tdata[p*DW +: DW]),
            .in_tvalid  (in_tvalid[p]),
            .in_tready  (in_tready[p]),
            .in_tlast   (in_tlast[p]),
            .in_tuser   (in_tuser[p]),
            .out_tdata  (fifo_tdata[p*DW +: DW]),
            .out_tvalid (fifo_tvalid[p]),
            .out_tready (fifo_tready[p]),
            .out_tlast  (fifo_tlast[p]),
            .out_tuser  (fifo_tuser[p])
        );
    end

    // ********************************************************************
    // arbitration and tagging
    // ********************************************************************

    axis_frame_arb #(
        .NUM_PORTS (NUM_PORTS)
    ) u_arb (
        .clk         (clk),
        .rst         (rst),
        .request     (fifo_tvalid),
        .frame_done  (frame_done),
        .grant       (grant),
        .grant_valid (grant_valid)
    );

    axis_tag_mux #(
        .NUM_PORTS (NUM_PORTS)
    ) u_mux (
        .clk         (clk),
        .rst         (rst),
        .grant       (grant),
        .grant_valid (grant_valid),
        .fifo_tdata  (fifo_tdata),
        .fifo_tvalid (fifo_tvalid),
        .fifo_tready (fifo_tready),
        .fifo_tlast  (fifo_tlast),
        .fifo_tuser  (fifo_tuser),
        .out_tdata   (out_tdata),
        .out_tvalid  (out_tvalid),
        .out_tready  (out_tready),
        .out_tlast   (out_tlast),
        .out_tuser   (out_tuser),
        .frame_done  (frame_done)
    );

endmodule

// File: axis_merge_asserts.sv
/*
 * Protocol checks on the merged output stream and on the arbiter grant.
 * Bound into the top level, so it sees the internal grant signals by name.
 * A frame is taken to start on the first beat after reset or after a tlast beat.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module axis_merge_asserts (
    input logic                        clk,
    input logic                        rst,
    input logic [`AXIS_DATA_WIDTH-1:0] out_tdata,
    input logic                        out_tvalid,
    input logic                        out_tready,
    input logic                        out_tlast,
    input logic                        out_tuser,
    input arb_pkg::port_idx_t          grant,
    input logic                        grant_valid
);

    logic hdr_next; // the next accepted beat opens a frame.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr_next <= 1'b1;
        end else if (out_tvalid && out_tready) begin
            hdr_next <= out_tlast; // a tlast beat is followed by a header.
        end
    end

    // a stalled beat stays on the bus unchanged.
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && !out_tready |=> out_tvalid && $stable({out_tdata, out_tlast, out_tuser}))
        else $error("output beat changed while stalled");

    hdr_no_last: assert property (@(posedge clk) disable iff (rst)
        out_tvalid && hdr_next |-> !out_tlast)
        else $error("header beat carries tlast");

    grant_hold: assert property (@(posedge clk) disable iff (rst)
        grant_valid |=> !grant_valid || $stable(grant))
        else $error("grant moved while grant_valid was high");

endmodule

bind axis_merge_top axis_merge_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .out_tdata   (out_tdata),
    .out_tvalid  (out_tvalid),
    .out_tready  (out_tready),
    .out_tlast   (out_tlast),
    .out_tuser   (out_tuser),
    .grant       (grant),
    .grant_valid (grant_valid)
);

// File: tb_axis_merge.sv
/*
 * Testbench for the stream merger with random frame sources and random output stalls.
 * A per-port model keeps every beat the DUT accepted and the expected sequence number.
 * Phase sizes assume the default build of 3 ports and 16-entry port FIFOs.
 * Inputs change 1 ns after the rising edge and all handshakes are sampled on the falling edge.
 */
`timescale 1ns/100ps
`include "axis_cfg.svh"

module tb_axis_merge;

    import stream_pkg::*;

    localparam int NP  = `AXIS_NUM_PORTS;
    localparam int DW  = `AXIS_DATA_WIDTH;
    localparam int CAP = (1 << `AXIS_FIFO_ADDR_WIDTH) + 1; // memory plus output register.
    localparam int ALL = (1 << NP) - 1;

    logic             clk = 1'b0;
    logic             rst;
    logic [NP*DW-1:0] in_tdata;
    logic [NP-1:0]    in_tvalid;
    logic [NP-1:0]    in_tready;
    logic [NP-1:0]    in_tlast;
    logic [NP-1:0]    in_tuser;
    logic [DW-1:0]    out_tdata;
    logic             out_tvalid;
    logic             out_tready;
    logic             out_tlast;
    logic             out_tuser;

    logic [DW+1:0] send_q [NP][$]; // beats still at each source, {tlast, tuser, tdata}.
    logic [DW+1:0] exp_q [NP][$]; // beats inside the DUT, oldest first.
    int            frames_left [NP]; // frames each source has yet to start.
    int            gap [NP]; // idle cycles before the next frame starts.
    int            exp_seq [NP];
    int            frames_out [NP];
    int            acc_cnt [NP]; // beats taken by each port since the full test began.
    bit            was_full [NP];
    bit [NP-1:0]   seen_since [NP]; // ports output since each port's last frame.
    bit            busy_mark [NP];
    bit            appeared [NP];
    int            stall_pct; // chance in percent of out_tready being low.
    int            gap_max;
    bit            hold_stall; // keeps out_tready low.
    bit            fair_on;
    bit            in_frame; // monitor is inside a frame, past its header.
    int            cur_src;

    axis_merge_top dut (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (in_tdata),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .out_tdata  (out_tdata),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .out_tuser  (out_tuser)
    );

    initial begin : clock
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period.
    end

    // ********************************************************************
    // checking
    // ********************************************************************

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_eq(input longint got, input longint exp, input string what);
        if (got != exp) begin
            abort_run($sformatf("MISMATCH at %0t ns: %s, got %0h, expected %0h",
                                $time, what, got, exp));
        end
    endtask

    // true while every source still has frame data to hand over.
    function automatic bit all_busy();
        for (int q = 0; q < NP; q++) begin
            if (frames_left[q] == 0 && send_q[q].size() == 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic take_header(input logic [DW-1:0] data, input logic last, input logic user);
        out_word_u hw;
        int        src;
        hw.raw = data; // first beat of a frame is read as a header.
        src    = int'(hw.hdr.src);
        check_eq({last, user}, 0, "header tlast and tuser");
        check_eq(src < NP, 1, "header source in range");
        check_eq(hw.hdr.seq, exp_seq[src], $sformatf("sequence number of port %0d", src));
        // with all sources loaded, every other port must be served before src comes back.
        if (fair_on && appeared[src] && busy_mark[src] && all_busy()) begin
            check_eq(seen_since[src], ALL & ~(1 << src),
                     $sformatf("ports served between two frames of port %0d", src));
        end
        for (int q = 0; q < NP; q++) begin
            seen_since[q][src] = 1'b1;
        end
        seen_since[src] = '0;
        appeared[src]   = 1'b1;
        busy_mark[src]  = all_busy();
        cur_src         = src;
        in_frame        = 1'b1;
    endtask

    task automatic take_payload(input logic [DW-1:0] data, input logic last, input logic user);
        logic [DW+1:0] beat;
        if (exp_q[cur_src].size() == 0) begin
            abort_run($sformatf("output carried a beat for port %0d that was never sent, at %0t ns",
                                cur_src, $time));
        end else begin
            beat = exp_q[cur_src].pop_front();
            check_eq({last, user, data}, beat, $sformatf("payload beat of port %0d", cur_src));
            if (last) begin
                in_frame            = 1'b0;
                exp_seq[cur_src]    = (exp_seq[cur_src] + 1) % (1 << SEQ_W); // 6-bit wrap.
                frames_out[cur_src] = frames_out[cur_src] + 1;
            end
        end
    endtask

    // ********************************************************************
    // stimulus and monitor
    // ********************************************************************

    task automatic drive_cycle();
        int len;
        out_tready = !hold_stall && ($urandom_range(99) >= stall_pct);
        for (int p = 0; p < NP; p++) begin
            if (send_q[p].size() == 0 && gap[p] > 0) begin
                gap[p] = gap[p] - 1;
            end else if (send_q[p].size() == 0 && frames_left[p] > 0) begin
                len = $urandom_range(12, 1); // frame of 1 to 12 bytes.
                for (int i = 0; i < len; i++) begin
                    send_q[p].push_back({i == len - 1, 1'($urandom_range(1)),
                                         DW'($urandom_range(255))});
                end
                frames_left[p] = frames_left[p] - 1;
                gap[p]         = $urandom_range(gap_max); // idle time after this frame.
            end
            in_tvalid[p] = (send_q[p].size() != 0); // head beat stays until it is taken.
            {in_tlast[p], in_tuser[p], in_tdata[p*DW +: DW]} = in_tvalid[p] ? send_q[p][0] : '0;
        end
    endtask

    task automatic sample_cycle();
        for (int p = 0; p < NP; p++) begin
            if (in_tvalid[p] && in_tready[p]) begin
                exp_q[p].push_back(send_q[p].pop_front()); // beat moves into the DUT.
                acc_cnt[p] = acc_cnt[p] + 1;
            end
            if (hold_stall && !in_tready[p] && !was_full[p]) begin
                was_full[p] = 1'b1;
                check_eq(acc_cnt[p] <= CAP, 1, $sformatf("beats taken by port %0d before full", p));
            end
        end
        if (out_tvalid && out_tready) begin
            if (in_frame) begin
                take_payload(out_tdata, out_tlast, out_tuser);
            end else begin
                take_header(out_tdata, out_tlast, out_tuser);
            end
        end
    endtask

    initial begin : driver
        forever begin
            @(posedge clk);
            #1;
            drive_cycle();
            @(negedge clk); // all handshake signals are settled here.
            if (!rst) begin
                sample_cycle();
            end
        end
    end

    // ********************************************************************
    // waits
    // ********************************************************************

    function automatic bit drained();
        for (int q = 0; q < NP; q++) begin
            if (frames_left[q] != 0 || send_q[q].size() != 0 || exp_q[q].size() != 0) begin
                return 1'b0;
            end
        end
        return !in_frame;
    endfunction

    function automatic bit all_full();
        for (int q = 0; q < NP; q++) begin
            if (!was_full[q]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drain(input int limit, input string what);
        int n;
        n = 0;
        while (!drained()) begin
            @(posedge clk);
            n = n + 1;
            if (n > limit) begin
                abort_run($sformatf("timeout after %0d cycles waiting for %s to leave the DUT",
                                    limit, what));
            end
        end
    endtask

    task automatic wait_full(input int limit);
        int n;
        n = 0;
        while (!all_full()) begin
            @(posedge clk);
            n = n + 1;
            if (n > limit) begin
                abort_run("timeout while waiting for every input port to drop tready");
            end
        end
    endtask

    // ********************************************************************
    // test sequence
    // ********************************************************************

    initial begin : main
        void'($urandom(70190)); // one seed for the whole run.
        rst        = 1'b1;
        in_tdata   = '0;
        in_tvalid  = '0;
        in_tlast   = '0;
        in_tuser   = '0;
        out_tready = 1'b0;
        @(negedge clk);
        check_eq(out_tvalid, 0, "out_tvalid during reset");
        check_eq(in_tready, ALL, "in_tready during reset");
        @(posedge clk);
        #1 rst = 1'b0; // reset spans two rising edges.
        @(negedge clk);
        check_eq(out_tvalid, 0, "out_tvalid after reset");
        check_eq(in_tready, ALL, "in_tready after reset");
        // one frame per port, in turn, with no stall.
        for (int p = 0; p < NP; p++) begin
            frames_left[p] = 1;
            wait_drain(500, "a single frame");
        end
        // all ports at once, first without and then with output stalls.
        gap_max = 6;
        for (int p = 0; p < NP; p++) begin
            frames_left[p] = 15;
        end
        wait_drain(20000, "concurrent traffic");
        stall_pct = 40;
        for (int p = 0; p < NP; p++) begin
            frames_left[p] = 15;
        end
        wait_drain(20000, "traffic under stalls");
        // fill every FIFO behind a blocked output, then release it.
        stall_pct  = 0;
        gap_max    = 0;
        hold_stall = 1'b1;
        for (int p = 0; p < NP; p++) begin
            acc_cnt[p]     = 0;
            was_full[p]    = 1'b0;
            frames_left[p] = 50;
        end
        wait_full(400);
        for (int p = 0; p < NP; p++) begin
            appeared[p]   = 1'b0;
            seen_since[p] = '0;
        end
        fair_on    = 1'b1;
        hold_stall = 1'b0;
        wait_drain(40000, "the backlog of full FIFOs");
        for (int p = 0; p < NP; p++) begin
            check_eq(frames_out[p] > (1 << SEQ_W), 1,
                     $sformatf("frames of port %0d past the sequence wrap", p));
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: sim.f
+incdir+.
stream_pkg.sv
arb_pkg.sv
axis_fifo.sv
axis_frame_arb.sv
axis_tag_mux.sv
axis_merge_top.sv
axis_merge_asserts.sv
tb_axis_merge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps
TOP       ?= tb_axis_merge
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
